/* Makefile */
SIM        ?= verilator
TOP        ?= tb_bridge
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation binary is the pass or fail result
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/bridge_assert.sv */
/*
 * Bound checks on the DRAM read handshake and the SPI and output idle levels
 */
`timescale 1ns/1ps

module bridge_assert (
    input  logic                     clk,
    input  logic                     rst_n,
    input  bridge_pkg::dram_rd_req_t dram_req,
    input  bridge_pkg::dram_rd_rsp_t dram_rsp,
    input  logic                     mosi,
    input  logic                     out_valid
);
    // Address held until the slave takes it
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (dram_req.ar_valid && !dram_rsp.ar_ready)
        |=> (dram_req.ar_valid && $stable(dram_req.ar_addr)))
        else $error("ar_valid or ar_addr changed before ar_ready");

    ar_r_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(dram_req.ar_valid && dram_req.r_ready))
        else $error("r_ready high while ar_valid is high");

    reset_idle: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (mosi && !out_valid))
        else $error("mosi or out_valid not idle around reset");

    // Eight bytes at most
    out_max8: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && $past(out_valid, 1) && $past(out_valid, 2) && $past(out_valid, 3)
         && $past(out_valid, 4) && $past(out_valid, 5) && $past(out_valid, 6)
         && $past(out_valid, 7)) |=> !out_valid)
        else $error("out_valid high for more than eight cycles");

endmodule

bind bridge_top bridge_assert i_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .dram_req  (dram_req),
    .dram_rsp  (dram_rsp),
    .mosi      (mosi),
    .out_valid (out_valid)
);

/* bench/bridge_stimulus.txt */
# addr_dram(hex) addr_sd(hex) dram_word(hex) ar_delay r_delay resp_delay busy_len
# delays and busy length are in clock cycles, decimal
0000 0000 0000000000000000 0 0 0 1
1fff ffff ffffffffffffffff 1 0 2 3
0a5c 1234 0123456789abcdef 3 2 1 5
1001 8000 8000000000000001 0 4 6 2
0123 00ff deadbeefcafef00d 5 1 0 12
1abc 7e7e a5a55a5a0ff0f00f 2 3 4 7
0fff 0001 fedcba9876543210 0 0 3 4
0042 c3a5 1122334455667788 4 0 1 9

/* bench/tb_bridge.sv */
/*
 * Testbench for the DRAM to SD card bridge
 * Replays the stimulus file through a DRAM slave and an SD card model
 */
`timescale 1ns/1ps

module tb_bridge;
    import bridge_pkg::*;
    import sd_spi_pkg::*;

    localparam int max_wait = 2000;   // Cycles per wait

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    logic [12:0]    addr_dram;
    logic [15:0]    addr_sd;
    dram_rd_req_t   dram_req;
    dram_rd_rsp_t   dram_rsp;
    logic           miso;
    logic           mosi;
    logic           out_valid;
    logic [7:0]     out_data;

    int             resp_delay;
    int             busy_len;
    sd_cmd_frame_t  cmd_frame;
    sd_data_frame_t data_frame;
    int             cmd_cnt;
    int             data_cnt;
    int             gap_len;
    int             low_bits;
    logic           released;
    int             ar_count = 0;
    logic           ar_valid_q = 1'b0;
    int             seed;

    bridge_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .addr_dram (addr_dram),
        .addr_sd   (addr_sd),
        .dram_req  (dram_req),
        .dram_rsp  (dram_rsp),
        .miso      (miso),
        .mosi      (mosi),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    tb_sd_card i_card (
        .clk        (clk),
        .rst_n      (rst_n),
        .mosi       (mosi),
        .miso       (miso),
        .resp_delay (resp_delay),
        .busy_len   (busy_len),
        .cmd_frame  (cmd_frame),
        .data_frame (data_frame),
        .cmd_cnt    (cmd_cnt),
        .data_cnt   (data_cnt),
        .gap_len    (gap_len),
        .low_bits   (low_bits),
        .released   (released)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        ar_valid_q <= dram_req.ar_valid;
        if (dram_req.ar_valid && !ar_valid_q)
            ar_count <= ar_count + 1;    // Read requests seen
    end

    // ########################################
    // Failure reporting and checks
    // ########################################
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_cmd(input string name, input sd_cmd_frame_t got,
                             input sd_cmd_frame_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_data(input string name, input sd_data_frame_t got,
                              input sd_data_frame_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    // ########################################
    // DRAM slave and waits
    // ########################################
    task automatic serve_read(input logic [31:0] exp_addr, input logic [63:0] word,
                              input int ar_dly, input int r_dly);
        int n;
        int pause;
        n = 0;
        @(negedge clk);
        while (!dram_req.ar_valid) begin
            n++;
            if (n > max_wait)
                fail_run("Timeout: ar_valid never rose");
            @(negedge clk);
        end
        pause = ar_dly + int'($unsigned($random(seed)) % 3);    // Ready jitter
        repeat (pause) begin
            check_addr("ar_addr", dram_req.ar_addr, exp_addr);
            @(negedge clk);
        end
        @(posedge clk);
        #1 dram_rsp.ar_ready = 1'b1;
        @(negedge clk);
        if (!dram_req.ar_valid)
            fail_run("ar_valid dropped before the slave raised ar_ready");
        check_addr("ar_addr", dram_req.ar_addr, exp_addr);
        @(posedge clk);
        #1 dram_rsp.ar_ready = 1'b0;
        n = 0;
        @(negedge clk);
        if (dram_req.ar_valid)
            fail_run("ar_valid stayed high after the address handshake");
        while (!dram_req.r_ready) begin
            n++;
            if (n > max_wait)
                fail_run("Timeout: r_ready never rose after the address handshake");
            @(negedge clk);
        end
        pause = r_dly + int'($unsigned($random(seed)) % 3);
        repeat (pause) @(negedge clk);
        @(posedge clk);
        #1;
        dram_rsp.r_valid = 1'b1;
        dram_rsp.r_data  = word;
        @(negedge clk);
        if (!dram_req.r_ready)
            fail_run("r_ready dropped before r_valid");
        @(posedge clk);
        #1;
        dram_rsp.r_valid = 1'b0;
        dram_rsp.r_data  = '0;
    endtask

    task automatic wait_cmd_frame(input int target);
        int n;
        n = 0;
        while (cmd_cnt < target) begin
            @(posedge clk);
            n++;
            if (n > max_wait)
                fail_run("Timeout: the card saw no command frame");
        end
    endtask

    task automatic wait_data_frame(input int target);
        int n;
        n = 0;
        while (data_cnt < target) begin
            @(posedge clk);
            n++;
            if (n > max_wait)
                fail_run("Timeout: the card saw no data block");
        end
    endtask

    task automatic wait_out_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!out_valid) begin
            n++;
            if (n > max_wait)
                fail_run("Timeout: out_valid never rose");
            @(negedge clk);
        end
    endtask

    // ########################################
    // Main sequence
    // ########################################
    initial begin
        int             fd;
        int             txn;
        string          line;
        logic [12:0]    a_dram;
        logic [15:0]    a_sd;
        logic [63:0]    word;
        int             ar_dly;
        int             r_dly;
        int             c_dly;
        int             b_len;
        int             low_before;
        int             ar_before;
        sd_cmd_frame_t  exp_cmd;
        sd_data_frame_t exp_data;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        addr_dram  = '0;
        addr_sd    = '0;
        dram_rsp   = '0;
        resp_delay = 0;
        busy_len   = 1;
        seed       = 32'h366e_cc39;
        txn        = 0;
        fd = $fopen("bench/bridge_stimulus.txt", "r");
        if (fd == 0)
            fail_run("Cannot open bench/bridge_stimulus.txt");
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
                continue;
            if ($sscanf(line, "%h %h %h %d %d %d %d",
                        a_dram, a_sd, word, ar_dly, r_dly, c_dly, b_len) != 7)
                fail_run($sformatf("Malformed stimulus line %s", line));

            // Expected frames: start 01, CMD24, zero-extended block address
            exp_cmd = '{start: 2'b01, index: 6'd24, argument: {16'h0000, a_sd},
                        crc7: 7'h00, end_bit: 1'b1};
            exp_cmd.crc7 = crc7(exp_cmd[47:8]);
            exp_data = '{token: 8'hFE, data: word, crc16: crc16(word)};
            resp_delay = c_dly;
            busy_len   = b_len;

            @(posedge clk);
            #1;
            low_before = low_bits;
            ar_before  = ar_count;
            in_valid   = 1'b1;
            addr_dram  = a_dram;
            addr_sd    = a_sd;
            @(posedge clk);
            #1;
            in_valid  = 1'b0;
            addr_dram = '0;
            addr_sd   = '0;

            serve_read({19'h0, a_dram}, word, ar_dly, r_dly);
            wait_cmd_frame(txn + 1);
            check_cmd("cmd_frame", cmd_frame, exp_cmd);
            wait_data_frame(txn + 1);
            check_data("data_frame", data_frame, exp_data);
            check_count("gap_len", gap_len, 8);

            wait_out_valid();
            if (!released)
                fail_run("out_valid rose while the card was still busy");
            for (int i = 0; i < 8; i++) begin
                if (!out_valid)
                    fail_run("out_valid fell before all eight bytes");
                check_byte("out_data", out_data, word[63-8*i -: 8]);
                @(negedge clk);
            end
            if (out_valid)
                fail_run("out_valid stayed high after eight bytes");
            check_count("ar_requests", ar_count - ar_before, 1);
            // Any stray low bit between frames shows up here
            check_count("mosi_low_bits", low_bits - low_before,
                        136 - $countones(exp_cmd) - $countones(exp_data));
            txn++;
        end
        $fclose(fd);
        if (txn == 0) begin
            fail_run("The stimulus file holds no transactions");
        end else begin
            $display("Ran %0d transactions", txn);
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* bench/tb_sd_card.sv */
/*
 * SD card model in SPI mode
 * Captures command and data frames from mosi and answers with R1, data response and busy
 */
`timescale 1ns/1ps

module tb_sd_card (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mosi,
    output logic                       miso,
    input  int                         resp_delay,   // Idle cycles before each response
    input  int                         busy_len,
    output sd_spi_pkg::sd_cmd_frame_t  cmd_frame,
    output sd_spi_pkg::sd_data_frame_t data_frame,
    output int                         cmd_cnt,
    output int                         data_cnt,
    output int                         gap_len,      // Idle bits between R1 and token
    output int                         low_bits,
    output logic                       released
);
    import sd_spi_pkg::*;

    localparam logic [7:0] r1_ready      = 8'h00;
    localparam logic [7:0] data_accepted = 8'h05;   // xxx0_010_1 form

    // Every low mosi bit, frames included
    always @(negedge clk) begin
        if (!rst_n)
            low_bits <= 0;
        else if (mosi === 1'b0)
            low_bits <= low_bits + 1;
    end

    task automatic send_byte(input logic [7:0] value);
        repeat (resp_delay) @(posedge clk);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk);
            #1 miso = value[i];
        end
    endtask

    initial begin
        sd_cmd_frame_t cmd;
        logic [7:0]    token;
        logic [79:0]   body;
        int            ones;
        miso       = 1'b1;
        cmd_cnt    = 0;
        data_cnt   = 0;
        gap_len    = 0;
        released   = 1'b0;
        cmd_frame  = '0;
        data_frame = '0;
        forever begin
            // ########################################
            // Command frame opens with a low bit
            // ########################################
            @(negedge clk);
            while (mosi !== 1'b0)
                @(negedge clk);
            released = 1'b0;
            cmd[47]  = 1'b0;
            for (int i = 46; i >= 0; i--) begin
                @(negedge clk);
                cmd[i] = mosi;
            end
            cmd_frame = cmd;
            cmd_cnt++;
            send_byte(r1_ready);
            @(posedge clk);
            #1 miso = 1'b1;

            // Count idle ones up to the zero that closes the token
            ones  = 0;
            token = 8'hFF;
            @(negedge clk);
            while (mosi !== 1'b0) begin
                ones++;
                token = {token[6:0], mosi};
                @(negedge clk);
            end
            token   = {token[6:0], 1'b0};
            gap_len = ones - 7;    // Token brings seven ones of its own
            for (int i = 79; i >= 0; i--) begin
                @(negedge clk);
                body[i] = mosi;
            end
            data_frame = {token, body};
            data_cnt++;

            // ########################################
            // Data response, then busy
            // ########################################
            send_byte(data_accepted);
            repeat (busy_len) begin
                @(posedge clk);
                #1 miso = 1'b0;
            end
            @(posedge clk);
            #1 miso  = 1'b1;
            released = 1'b1;
        end
    end

endmodule

/* build.f */
common/bridge_pkg.sv
common/sd_spi_pkg.sv
dram/dram_reader.sv
sd/sd_spi_tx.sv
sd/sd_spi_rx.sv
verilog/bridge_ctrl.sv
verilog/bridge_top.sv
bench/tb_sd_card.sv
bench/bridge_assert.sv
bench/tb_bridge.sv

/* common/bridge_pkg.sv */
/*
 * Bridge-wide widths, DRAM read-channel bundles and the controller states
 */
package bridge_pkg;

    // ########################################
    // Widths
    // ########################################
    localparam int dram_addr_w = 13;
    localparam int sd_addr_w   = 16;
    localparam int axi_addr_w  = 32;
    localparam int axi_data_w  = 64;
    localparam int out_bytes   = 8;     // Output word split into bytes, MSB first

    // ########################################
    // DRAM read channels
    // ########################################
    // Bridge to DRAM, 34 bits
    typedef struct packed {
        logic                  ar_valid;
        logic [axi_addr_w-1:0] ar_addr;
        logic                  r_ready;
    } dram_rd_req_t;

    // DRAM to bridge, 68 bits
    typedef struct packed {
        logic                  ar_ready;
        logic                  r_valid;
        logic [1:0]            r_resp;    // Observed only
        logic [axi_data_w-1:0] r_data;
    } dram_rd_rsp_t;

    // Controller phases in transaction order
    typedef enum logic [3:0] {
        st_idle,
        st_dram_read,
        st_send_cmd,
        st_cmd_resp,
        st_gap,
        st_send_data,
        st_data_resp,
        st_busy,
        st_output
    } bridge_state_t;

endpackage

/* common/sd_spi_pkg.sv */
/*
 * SD card SPI-mode constants, frame layouts, receiver modes and CRC helpers
 */
package sd_spi_pkg;

    localparam logic [1:0]  sd_cmd_start       = 2'b01;
    localparam logic [5:0]  sd_cmd_write_block = 6'd24;   // CMD24, single block write
    localparam logic [7:0]  sd_start_token     = 8'hFE;
    localparam int          sd_gap_bits        = 8;       // Idle bits after R1
    localparam int          sd_cmd_bits        = 48;
    localparam int          sd_data_bits       = 88;
    localparam logic [6:0]  crc7_poly          = 7'h09;   // x^7 + x^3 + 1
    localparam logic [15:0] crc16_poly         = 16'h1021; // CCITT

    // Command frame, sent MSB first
    typedef struct packed {
        logic [1:0]  start;
        logic [5:0]  index;
        logic [31:0] argument;
        logic [6:0]  crc7;
        logic        end_bit;
    } sd_cmd_frame_t;

    // Single block data frame with start token
    typedef struct packed {
        logic [7:0]  token;
        logic [63:0] data;
        logic [15:0] crc16;
    } sd_data_frame_t;

    typedef enum logic {
        rx_byte,    // Wait for a start bit, then eight bits
        rx_busy     // Wait for the card to release miso
    } sd_rx_mode_t;

    typedef enum logic {
        tx_cmd,
        tx_data
    } sd_tx_kind_t;

    // CRC7 over start, index and argument
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb)
                crc = crc ^ crc7_poly;
        end
        return crc;
    endfunction

    // CRC16-CCITT over the data word, register starts at zero
    function automatic logic [15:0] crc16(input logic [63:0] bits);
        logic [15:0] crc;
        logic        fb;
        crc = '0;
        for (int i = 63; i >= 0; i--) begin
            fb  = bits[i] ^ crc[15];
            crc = {crc[14:0], 1'b0};
            if (fb)
                crc = crc ^ crc16_poly;
        end
        return crc;
    endfunction

endpackage

/* dram/dram_reader.sv */
/*
 * DRAM read master, one AR beat then one R beat, holds the returned word
 */
`timescale 1ns/1ps

module dram_reader (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [bridge_pkg::dram_addr_w-1:0]  addr,
    output logic                                done,
    output logic [bridge_pkg::axi_data_w-1:0]   data,
    output bridge_pkg::dram_rd_req_t            dram_req,
    input  bridge_pkg::dram_rd_rsp_t            dram_rsp
);
    import bridge_pkg::*;

    logic                  ar_valid;
    logic [axi_addr_w-1:0] ar_addr;
    logic                  r_ready;

    assign dram_req = '{ar_valid: ar_valid, ar_addr: ar_addr, r_ready: r_ready};
    assign done     = r_ready && dram_rsp.r_valid;   // Same cycle as the R handshake

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
        end else if (start) begin
            ar_valid <= 1'b1;
        end else if (ar_valid && dram_rsp.ar_ready) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b1;     // R phase opens right after AR
        end else if (done) begin
            r_ready <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            ar_addr <= axi_addr_w'(addr);    // Zero-extended
        if (done)
            data <= dram_rsp.r_data;
    end

endmodule

/* sd/sd_spi_rx.sv */
/*
 * SD SPI receiver, skips a response byte or waits out the card's busy period
 */
`timescale 1ns/1ps

module sd_spi_rx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  sd_spi_pkg::sd_rx_mode_t  mode,
    input  logic                     miso,
    output logic                     done
);
    import sd_spi_pkg::*;

    sd_rx_mode_t mode_q;
    logic        active;
    logic        in_byte;    // Start bit seen, counting the rest
    logic [2:0]  bit_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q  <= rx_byte;
            active  <= 1'b0;
            in_byte <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                mode_q  <= mode;
                active  <= 1'b1;
                in_byte <= 1'b0;
                bit_cnt <= '0;
            end else if (active) begin
                if (mode_q == rx_busy) begin
                    // Card pulls miso low while programming
                    if (miso) begin
                        active <= 1'b0;
                        done   <= 1'b1;
                    end
                end else if (!in_byte) begin
                    if (!miso) begin
                        in_byte <= 1'b1;
                        bit_cnt <= 3'd1;   // Leading zero is bit one
                    end
                end else begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin   // Eighth bit sampled now
                        active  <= 1'b0;
                        in_byte <= 1'b0;
                        done    <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* sd/sd_spi_tx.sv */
/*
 * SD SPI transmitter
 * Builds a CMD24 or data-block frame with its CRC and shifts it out on mosi
 */
`timescale 1ns/1ps

module sd_spi_tx (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  sd_spi_pkg::sd_tx_kind_t            kind,
    input  logic [bridge_pkg::sd_addr_w-1:0]   sd_addr,
    input  logic [bridge_pkg::axi_data_w-1:0]  data,
    output logic                               done,
    output logic                               mosi
);
    import sd_spi_pkg::*;

    sd_cmd_frame_t           cmd_frame;
    sd_data_frame_t          data_frame;
    logic [sd_data_bits-1:0] shreg;
    logic [6:0]              bit_cnt;    // Bits left after the current one
    logic                    active;

    // ########################################
    // Frame build
    // ########################################
    assign cmd_frame = '{
        start:    sd_cmd_start,
        index:    sd_cmd_write_block,
        argument: 32'(sd_addr),
        crc7:     crc7({sd_cmd_start, sd_cmd_write_block, 32'(sd_addr)}),
        end_bit:  1'b1
    };

    assign data_frame = '{token: sd_start_token, data: data, crc16: crc16(data)};

    // ########################################
    // Serializer
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (start) begin
            active  <= 1'b1;
            bit_cnt <= (kind == tx_cmd) ? 7'(sd_cmd_bits - 1) : 7'(sd_data_bits - 1);
        end else if (active) begin
            if (bit_cnt == '0)
                active <= 1'b0;
            else
                bit_cnt <= bit_cnt - 7'd1;
        end
    end

    // Command sits at the top, the tail is never shifted out
    always_ff @(posedge clk) begin
        if (start) begin
            if (kind == tx_cmd)
                shreg <= {cmd_frame, {(sd_data_bits - sd_cmd_bits){1'b0}}};
            else
                shreg <= data_frame;
        end else if (active) begin
            shreg <= shreg << 1;
        end
    end

    assign mosi = active ? shreg[sd_data_bits-1] : 1'b1;   // Line idles high
    assign done = active && (bit_cnt == '0);

endmodule

/* verilog/bridge_ctrl.sv */
/*
 * Bridge controller
 * Walks one transaction from DRAM read to SD block write, then emits the word bytewise
 */
`timescale 1ns/1ps

module bridge_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [bridge_pkg::dram_addr_w-1:0]  addr_dram,
    input  logic [bridge_pkg::sd_addr_w-1:0]    addr_sd,
    output logic                                rd_start,
    output logic [bridge_pkg::dram_addr_w-1:0]  rd_addr,
    input  logic                                rd_done,
    input  logic [bridge_pkg::axi_data_w-1:0]   rd_data,
    output logic [bridge_pkg::sd_addr_w-1:0]    sd_addr,
    output logic                                tx_start,
    output sd_spi_pkg::sd_tx_kind_t             tx_kind,
    input  logic                                tx_done,
    output logic                                rx_start,
    output sd_spi_pkg::sd_rx_mode_t             rx_mode,
    input  logic                                rx_done,
    output logic                                out_valid,
    output logic [7:0]                          out_data
);
    import bridge_pkg::*;
    import sd_spi_pkg::*;

    bridge_state_t state;
    bridge_state_t state_nxt;
    logic [3:0]    cnt;        // Gap bits, then output bytes
    logic          accept;
    logic          gap_end;
    logic [7:0]    out_byte;

    assign accept  = (state == st_idle) && in_valid;
    assign gap_end = (state == st_gap) && (cnt == sd_gap_bits - 1);

    // Byte cnt of the held word, MSB first
    assign out_byte = rd_data[8*(out_bytes-1-cnt[2:0]) +: 8];

    // ########################################
    // Address capture
    // ########################################
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_addr <= addr_dram;
            sd_addr <= addr_sd;
        end
    end

    // ########################################
    // State machine
    // ########################################
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:      if (accept)  state_nxt = st_dram_read;
            st_dram_read: if (rd_done) state_nxt = st_send_cmd;
            st_send_cmd:  if (tx_done) state_nxt = st_cmd_resp;
            st_cmd_resp:  if (rx_done) state_nxt = st_gap;
            st_gap:       if (gap_end) state_nxt = st_send_data;
            st_send_data: if (tx_done) state_nxt = st_data_resp;
            st_data_resp: if (rx_done) state_nxt = st_busy;
            st_busy:      if (rx_done) state_nxt = st_output;
            st_output:    if (cnt == out_bytes) state_nxt = st_idle;
            default:      state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            rd_start <= 1'b0;
        end else begin
            state    <= state_nxt;
            rd_start <= accept;    // ar_valid then rises one cycle later
        end
    end

    // Command goes out right on the read-data handshake
    assign tx_start = ((state == st_dram_read) && rd_done) || gap_end;
    assign tx_kind  = (state == st_gap) ? tx_data : tx_cmd;

    // Receiver armed as soon as the previous phase finishes
    assign rx_start = ((state == st_send_cmd) && tx_done)
                   || ((state == st_send_data) && tx_done)
                   || ((state == st_data_resp) && rx_done);
    assign rx_mode  = (state == st_data_resp) ? rx_busy : rx_byte;

    // ########################################
    // Shared counter and byte output
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            case (state)
                st_cmd_resp: begin
                    if (rx_done)
                        cnt <= 4'd1;       // rx_done cycle is the first idle bit
                end
                st_gap: begin
                    cnt <= gap_end ? 4'd0 : cnt + 4'd1;
                end
                st_busy: begin
                    if (rx_done) begin
                        out_valid <= 1'b1;
                        out_data  <= out_byte;    // cnt is 0 here
                        cnt       <= 4'd1;
                    end
                end
                st_output: begin
                    if (cnt == out_bytes) begin
                        out_valid <= 1'b0;
                        out_data  <= '0;
                        cnt       <= '0;
                    end else begin
                        out_data <= out_byte;
                        cnt      <= cnt + 4'd1;
                    end
                end
                default: begin
                    cnt <= '0;
                end
            endcase
        end
    end

endmodule

/* verilog/bridge_top.sv */
/*
 * DRAM to SD card bridge, top level
 * Ties the controller to the DRAM reader and the SPI transmit and receive units
 */
`timescale 1ns/1ps

module bridge_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [bridge_pkg::dram_addr_w-1:0]  addr_dram,
    input  logic [bridge_pkg::sd_addr_w-1:0]    addr_sd,
    output bridge_pkg::dram_rd_req_t            dram_req,
    input  bridge_pkg::dram_rd_rsp_t            dram_rsp,
    input  logic                                miso,
    output logic                                mosi,
    output logic                                out_valid,
    output logic [7:0]                          out_data
);
    import bridge_pkg::*;
    import sd_spi_pkg::*;

    // ########################################
    // Internal wires
    // ########################################
    logic                   rd_start;
    logic [dram_addr_w-1:0] rd_addr;
    logic                   rd_done;
    logic [axi_data_w-1:0]  rd_data;   // Held by the reader until the next read

    logic                   tx_start;
    sd_tx_kind_t            tx_kind;
    logic                   tx_done;
    logic [sd_addr_w-1:0]   sd_addr;

    logic                   rx_start;
    sd_rx_mode_t            rx_mode;
    logic                   rx_done;

    bridge_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .addr_dram (addr_dram),
        .addr_sd   (addr_sd),
        .rd_start  (rd_start),
        .rd_addr   (rd_addr),
        .rd_done   (rd_done),
        .rd_data   (rd_data),
        .sd_addr   (sd_addr),
        .tx_start  (tx_start),
        .tx_kind   (tx_kind),
        .tx_done   (tx_done),
        .rx_start  (rx_start),
        .rx_mode   (rx_mode),
        .rx_done   (rx_done),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    dram_reader i_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (rd_start),
        .addr     (rd_addr),
        .done     (rd_done),
        .data     (rd_data),
        .dram_req (dram_req),
        .dram_rsp (dram_rsp)
    );

    sd_spi_tx i_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (tx_start),
        .kind    (tx_kind),
        .sd_addr (sd_addr),
        .data    (rd_data),
        .done    (tx_done),
        .mosi    (mosi)
    );

    sd_spi_rx i_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .start (rx_start),
        .mode  (rx_mode),
        .miso  (miso),
        .done  (rx_done)
    );

endmodule
